//--- common/tageGeomPkg.sv
package tageGeomPkg;

    // fetch address and global history
    localparam int PcWidth = 32;
    localparam int GhrLen = 64;

    // number of tagged tables behind the base table
    localparam int NumTagged = 3;

    // base table is indexed straight from PC bits 8..2
    localparam int BaseIdxW = 7;

    // tags fold the PC bits above the base index
    localparam int TagPcLo = BaseIdxW + 2;

    // history length seen by each tagged table
    localparam int HistLenT1 = 4;
    localparam int HistLenT2 = 16;
    localparam int HistLenT3 = 64;

    // index widths, table depth is 2**width
    localparam int IdxWT1 = 7;
    localparam int IdxWT2 = 8;
    localparam int IdxWT3 = 7;

    // tag widths grow with history length
    localparam int TagWT1 = 7;
    localparam int TagWT2 = 8;
    localparam int TagWT3 = 9;

    typedef logic [PcWidth-1:0] pcT;

    // bit 0 holds the newest outcome
    typedef logic [GhrLen-1:0] ghrT;

endpackage

//--- common/tageEntryPkg.sv
package tageEntryPkg;

    // 3-bit saturating direction counter, upper half predicts taken
    typedef logic [2:0] ctrT;

    localparam ctrT CtrReset = 3'd3;
    localparam ctrT CtrWeakTaken = 3'd4;
    localparam ctrT CtrWeakNotTaken = 3'd3;

    // 0 is the base table, 1..3 the tagged tables
    typedef logic [1:0] providerT;

    localparam providerT ProvBase = 2'd0;
    localparam providerT ProvLongest = providerT'(tageGeomPkg::NumTagged);

    typedef struct packed {
        ctrT ctr;
    } baseEntryT;

    typedef struct packed {
        logic valid;
        logic [tageGeomPkg::TagWT1-1:0] tag;
        ctrT ctr;
    } tagEntry1T;

    typedef struct packed {
        logic valid;
        logic [tageGeomPkg::TagWT2-1:0] tag;
        ctrT ctr;
    } tagEntry2T;

    typedef struct packed {
        logic valid;
        logic [tageGeomPkg::TagWT3-1:0] tag;
        ctrT ctr;
    } tagEntry3T;

    // contents after reset, tagged entries start invalid
    localparam baseEntryT BaseEntryReset = '{ctr: CtrReset};
    localparam tagEntry1T TagEntry1Reset = '{valid: 1'b0, tag: '0, ctr: CtrReset};
    localparam tagEntry2T TagEntry2Reset = '{valid: 1'b0, tag: '0, ctr: CtrReset};
    localparam tagEntry3T TagEntry3Reset = '{valid: 1'b0, tag: '0, ctr: CtrReset};

endpackage

//--- verilog/indexHash.sv
`timescale 1ns/1ps

module indexHash #(
    parameter int HistLen = 4,
    parameter int IdxW = 7,
    parameter int TagW = 7
) (
    input  tageGeomPkg::pcT  Pc,
    input  tageGeomPkg::ghrT Ghr,
    output logic [IdxW-1:0]  Index,
    output logic [TagW-1:0]  Tag
);
    import tageGeomPkg::*;

    logic [IdxW-1:0] ghrIdxFold;
    logic [TagW-1:0] ghrTagFold;
    logic [TagW-1:0] pcTagFold;

    // history folded into index-width chunks, newest bits land in chunk 0
    always_comb begin
        ghrIdxFold = '0;
        for (int i = 0; i < HistLen; i++) begin
            ghrIdxFold[i % IdxW] = ghrIdxFold[i % IdxW] ^ Ghr[i];
        end
    end

    // same history folded to tag width
    always_comb begin
        ghrTagFold = '0;
        for (int i = 0; i < HistLen; i++) begin
            ghrTagFold[i % TagW] = ghrTagFold[i % TagW] ^ Ghr[i];
        end
    end

    // upper PC bits folded to tag width, last chunk zero padded
    always_comb begin
        pcTagFold = '0;
        for (int i = TagPcLo; i < PcWidth; i++) begin
            pcTagFold[(i - TagPcLo) % TagW] = pcTagFold[(i - TagPcLo) % TagW] ^ Pc[i];
        end
    end

    // word-aligned PC bits above bit 1
    assign Index = Pc[IdxW+1:2] ^ ghrIdxFold;
    assign Tag = pcTagFold ^ ghrTagFold;

endmodule

//--- predict/predTable.sv
`timescale 1ns/1ps

module predTable #(
    parameter type EntryT = logic [2:0],
    parameter int Depth = 128,
    parameter EntryT ResetEntry = '0
) (
    input  logic                     Clk,
    input  logic                     rst,
    input  logic                     ReadEn,
    input  logic [$clog2(Depth)-1:0] ReadIdx,
    output EntryT                    ReadEntry,
    input  logic                     WriteEn,
    input  logic [$clog2(Depth)-1:0] WriteIdx,
    input  EntryT                    WriteEntry
);

    EntryT mem [Depth];

    // single write port
    // reset loads every entry with its reset value
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                mem[i] <= ResetEntry;
            end
        end else if (WriteEn) begin
            mem[WriteIdx] <= WriteEntry;
        end
    end

    // registered read
    // a write to the same entry this cycle is seen on the next read
    always_ff @(posedge Clk) begin
        if (rst) begin
            ReadEntry <= ResetEntry;
        end else if (ReadEn) begin
            ReadEntry <= mem[ReadIdx];
        end
    end

    // the update hash must be known and stay inside the table
    writeIdxRange: assert property (
        @(posedge Clk) disable iff (rst)
        WriteEn |-> (!$isunknown(WriteIdx) && (int'(WriteIdx) < Depth))
    ) else $error("predTable write index %0d outside depth %0d", WriteIdx, Depth);

endmodule

//--- predict/providerSelect.sv
`timescale 1ns/1ps

module providerSelect (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             Stall,
    input  logic                             LookupValid,
    input  logic [tageGeomPkg::TagWT1-1:0]   TagT1,
    input  logic [tageGeomPkg::TagWT2-1:0]   TagT2,
    input  logic [tageGeomPkg::TagWT3-1:0]   TagT3,
    input  tageEntryPkg::baseEntryT          EntryBase,
    input  tageEntryPkg::tagEntry1T          EntryT1,
    input  tageEntryPkg::tagEntry2T          EntryT2,
    input  tageEntryPkg::tagEntry3T          EntryT3,
    output logic                             PredictAble,
    output logic                             PredictTaken,
    output tageEntryPkg::providerT           PredictProvider,
    output tageEntryPkg::ctrT                PredictCounter
);
    import tageGeomPkg::*;
    import tageEntryPkg::*;

    logic lookValid;
    logic [TagWT1-1:0] tagQ1;
    logic [TagWT2-1:0] tagQ2;
    logic [TagWT3-1:0] tagQ3;
    logic hit1;
    logic hit2;
    logic hit3;
    providerT provNext;
    ctrT ctrNext;

    // first stage runs in step with the table read
    always_ff @(posedge Clk) begin
        if (rst) begin
            lookValid <= 1'b0;
        end else if (!Stall) begin
            lookValid <= LookupValid;
        end
    end

    // tags are captured with the same enable as the table read
    always_ff @(posedge Clk) begin
        if (LookupValid && !Stall) begin
            tagQ1 <= TagT1;
            tagQ2 <= TagT2;
            tagQ3 <= TagT3;
        end
    end

    assign hit1 = EntryT1.valid && (EntryT1.tag == tagQ1);
    assign hit2 = EntryT2.valid && (EntryT2.tag == tagQ2);
    assign hit3 = EntryT3.valid && (EntryT3.tag == tagQ3);

    // longest matching history wins over shorter ones and the base table
    always_comb begin
        if (hit3) begin
            provNext = 2'd3;
            ctrNext = EntryT3.ctr;
        end else if (hit2) begin
            provNext = 2'd2;
            ctrNext = EntryT2.ctr;
        end else if (hit1) begin
            provNext = 2'd1;
            ctrNext = EntryT1.ctr;
        end else begin
            provNext = ProvBase;
            ctrNext = EntryBase.ctr;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            PredictAble <= 1'b0;
            PredictTaken <= 1'b0;
            PredictProvider <= ProvBase;
            PredictCounter <= CtrReset;
        end else if (!Stall) begin
            PredictAble <= lookValid;
            PredictTaken <= (ctrNext >= CtrWeakTaken);
            PredictProvider <= provNext;
            PredictCounter <= ctrNext;
        end
    end

    // the first stage is cleared too so no prediction leaks out of reset
    noPredAfterReset: assert property (
        @(posedge Clk) $fell(rst) |=> !PredictAble
    ) else $error("PredictAble high right after reset");

endmodule

//--- update/updateUnit.sv
`timescale 1ns/1ps

module updateUnit (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             UpdateAble,
    input  tageGeomPkg::pcT                  UpPc,
    input  logic                             UpTaken,
    input  tageEntryPkg::providerT           UpProvider,
    input  tageEntryPkg::ctrT                UpCounter,
    output tageGeomPkg::ghrT                 Ghr,
    output logic                             WriteEnBase,
    output logic                             WriteEnT1,
    output logic                             WriteEnT2,
    output logic                             WriteEnT3,
    output logic [tageGeomPkg::BaseIdxW-1:0] WriteIdxBase,
    output logic [tageGeomPkg::IdxWT1-1:0]   WriteIdxT1,
    output logic [tageGeomPkg::IdxWT2-1:0]   WriteIdxT2,
    output logic [tageGeomPkg::IdxWT3-1:0]   WriteIdxT3,
    output tageEntryPkg::baseEntryT          WriteEntryBase,
    output tageEntryPkg::tagEntry1T          WriteEntryT1,
    output tageEntryPkg::tagEntry2T          WriteEntryT2,
    output tageEntryPkg::tagEntry3T          WriteEntryT3
);
    import tageGeomPkg::*;
    import tageEntryPkg::*;

    logic [TagWT1-1:0] tagT1;
    logic [TagWT2-1:0] tagT2;
    logic [TagWT3-1:0] tagT3;
    ctrT trainCtr;
    ctrT allocCtr;
    logic mispredict;
    logic allocate;

    // hashes see the history as it was before this branch
    indexHash #(.HistLen(HistLenT1), .IdxW(IdxWT1), .TagW(TagWT1)) upHashT1 (
        .Pc(UpPc),
        .Ghr(Ghr),
        .Index(WriteIdxT1),
        .Tag(tagT1)
    );

    indexHash #(.HistLen(HistLenT2), .IdxW(IdxWT2), .TagW(TagWT2)) upHashT2 (
        .Pc(UpPc),
        .Ghr(Ghr),
        .Index(WriteIdxT2),
        .Tag(tagT2)
    );

    indexHash #(.HistLen(HistLenT3), .IdxW(IdxWT3), .TagW(TagWT3)) upHashT3 (
        .Pc(UpPc),
        .Ghr(Ghr),
        .Index(WriteIdxT3),
        .Tag(tagT3)
    );

    assign WriteIdxBase = UpPc[BaseIdxW+1:2];

    // saturating train of the returned counter
    always_comb begin
        trainCtr = UpCounter;
        if (UpTaken && (UpCounter != '1)) begin
            trainCtr = UpCounter + 3'd1;
        end else if (!UpTaken && (UpCounter != '0)) begin
            trainCtr = UpCounter - 3'd1;
        end
    end

    assign mispredict = (UpCounter >= CtrWeakTaken) != UpTaken;
    assign allocate = mispredict && (UpProvider < ProvLongest);
    assign allocCtr = UpTaken ? CtrWeakTaken : CtrWeakNotTaken;

    // a table is either trained as provider or allocated as provider+1, never both
    assign WriteEnBase = UpdateAble && (UpProvider == ProvBase);
    assign WriteEnT1 = UpdateAble && ((UpProvider == 2'd1) || (allocate && UpProvider == 2'd0));
    assign WriteEnT2 = UpdateAble && ((UpProvider == 2'd2) || (allocate && UpProvider == 2'd1));
    assign WriteEnT3 = UpdateAble && ((UpProvider == 2'd3) || (allocate && UpProvider == 2'd2));

    assign WriteEntryBase = '{ctr: trainCtr};
    assign WriteEntryT1 = '{valid: 1'b1, tag: tagT1,
                            ctr: (UpProvider == 2'd1) ? trainCtr : allocCtr};
    assign WriteEntryT2 = '{valid: 1'b1, tag: tagT2,
                            ctr: (UpProvider == 2'd2) ? trainCtr : allocCtr};
    assign WriteEntryT3 = '{valid: 1'b1, tag: tagT3,
                            ctr: (UpProvider == 2'd3) ? trainCtr : allocCtr};

    // newest outcome enters at bit 0
    always_ff @(posedge Clk) begin
        if (rst) begin
            Ghr <= '0;
        end else if (UpdateAble) begin
            Ghr <= {Ghr[GhrLen-2:0], UpTaken};
        end
    end

    upProviderKnown: assert property (
        @(posedge Clk) disable iff (rst)
        UpdateAble |-> (!$isunknown(UpProvider) && (UpProvider <= ProvLongest))
    ) else $error("update with bad provider %0d", UpProvider);

endmodule

//--- verilog/tageTop.sv
`timescale 1ns/1ps

module tageTop (
    input  logic                   Clk,
    input  logic                   rst,
    input  logic                   TageStop,
    input  logic                   PcAble,
    input  tageGeomPkg::pcT        PcAddr,
    input  logic                   UpdateAble,
    input  tageGeomPkg::pcT        UpPc,
    input  logic                   UpTaken,
    input  tageEntryPkg::providerT UpProvider,
    input  tageEntryPkg::ctrT      UpCounter,
    output logic                   PredictAble,
    output logic                   PredictTaken,
    output tageEntryPkg::providerT PredictProvider,
    output tageEntryPkg::ctrT      PredictCounter
);
    import tageGeomPkg::*;
    import tageEntryPkg::*;

    ghrT ghr;
    logic readEn;

    logic [IdxWT1-1:0] lookIdxT1;
    logic [IdxWT2-1:0] lookIdxT2;
    logic [IdxWT3-1:0] lookIdxT3;
    logic [TagWT1-1:0] lookTagT1;
    logic [TagWT2-1:0] lookTagT2;
    logic [TagWT3-1:0] lookTagT3;

    baseEntryT entryBase;
    tagEntry1T entryT1;
    tagEntry2T entryT2;
    tagEntry3T entryT3;

    logic wrEnBase;
    logic wrEnT1;
    logic wrEnT2;
    logic wrEnT3;
    logic [BaseIdxW-1:0] wrIdxBase;
    logic [IdxWT1-1:0] wrIdxT1;
    logic [IdxWT2-1:0] wrIdxT2;
    logic [IdxWT3-1:0] wrIdxT3;
    baseEntryT wrEntryBase;
    tagEntry1T wrEntryT1;
    tagEntry2T wrEntryT2;
    tagEntry3T wrEntryT3;

    // a stall freezes the table read along with the select stage
    assign readEn = PcAble && !TageStop;

    indexHash #(.HistLen(HistLenT1), .IdxW(IdxWT1), .TagW(TagWT1)) lookHashT1 (
        .Pc(PcAddr), .Ghr(ghr), .Index(lookIdxT1), .Tag(lookTagT1)
    );
    indexHash #(.HistLen(HistLenT2), .IdxW(IdxWT2), .TagW(TagWT2)) lookHashT2 (
        .Pc(PcAddr), .Ghr(ghr), .Index(lookIdxT2), .Tag(lookTagT2)
    );
    indexHash #(.HistLen(HistLenT3), .IdxW(IdxWT3), .TagW(TagWT3)) lookHashT3 (
        .Pc(PcAddr), .Ghr(ghr), .Index(lookIdxT3), .Tag(lookTagT3)
    );

    predTable #(.EntryT(baseEntryT), .Depth(1 << BaseIdxW), .ResetEntry(BaseEntryReset))
    baseTable (
        .Clk(Clk), .rst(rst),
        .ReadEn(readEn), .ReadIdx(PcAddr[BaseIdxW+1:2]), .ReadEntry(entryBase),
        .WriteEn(wrEnBase), .WriteIdx(wrIdxBase), .WriteEntry(wrEntryBase)
    );
    predTable #(.EntryT(tagEntry1T), .Depth(1 << IdxWT1), .ResetEntry(TagEntry1Reset))
    table1 (
        .Clk(Clk), .rst(rst),
        .ReadEn(readEn), .ReadIdx(lookIdxT1), .ReadEntry(entryT1),
        .WriteEn(wrEnT1), .WriteIdx(wrIdxT1), .WriteEntry(wrEntryT1)
    );
    predTable #(.EntryT(tagEntry2T), .Depth(1 << IdxWT2), .ResetEntry(TagEntry2Reset))
    table2 (
        .Clk(Clk), .rst(rst),
        .ReadEn(readEn), .ReadIdx(lookIdxT2), .ReadEntry(entryT2),
        .WriteEn(wrEnT2), .WriteIdx(wrIdxT2), .WriteEntry(wrEntryT2)
    );
    predTable #(.EntryT(tagEntry3T), .Depth(1 << IdxWT3), .ResetEntry(TagEntry3Reset))
    table3 (
        .Clk(Clk), .rst(rst),
        .ReadEn(readEn), .ReadIdx(lookIdxT3), .ReadEntry(entryT3),
        .WriteEn(wrEnT3), .WriteIdx(wrIdxT3), .WriteEntry(wrEntryT3)
    );

    providerSelect select (
        .Clk(Clk), .rst(rst), .Stall(TageStop), .LookupValid(PcAble),
        .TagT1(lookTagT1), .TagT2(lookTagT2), .TagT3(lookTagT3),
        .EntryBase(entryBase), .EntryT1(entryT1), .EntryT2(entryT2), .EntryT3(entryT3),
        .PredictAble(PredictAble), .PredictTaken(PredictTaken),
        .PredictProvider(PredictProvider), .PredictCounter(PredictCounter)
    );

    // updates bypass the stall
    updateUnit update (
        .Clk(Clk), .rst(rst),
        .UpdateAble(UpdateAble), .UpPc(UpPc), .UpTaken(UpTaken),
        .UpProvider(UpProvider), .UpCounter(UpCounter), .Ghr(ghr),
        .WriteEnBase(wrEnBase), .WriteEnT1(wrEnT1), .WriteEnT2(wrEnT2), .WriteEnT3(wrEnT3),
        .WriteIdxBase(wrIdxBase), .WriteIdxT1(wrIdxT1), .WriteIdxT2(wrIdxT2),
        .WriteIdxT3(wrIdxT3),
        .WriteEntryBase(wrEntryBase), .WriteEntryT1(wrEntryT1), .WriteEntryT2(wrEntryT2),
        .WriteEntryT3(wrEntryT3)
    );

endmodule

//--- verif/tageRefModel.svh
`ifndef TAGE_REF_MODEL_SVH
`define TAGE_REF_MODEL_SVH

// behavioral predictor state, row 0 is the base table
int refCtr [0:3][0:255];
bit refValid [0:3][0:255];
bit [31:0] refTag [0:3][0:255];
bit [63:0] refGhr;

function automatic int histOf(input int t);
    return (t == 1) ? HistLenT1 : (t == 2) ? HistLenT2 : HistLenT3;
endfunction

function automatic int idxWOf(input int t);
    return (t == 0) ? BaseIdxW : (t == 1) ? IdxWT1 : (t == 2) ? IdxWT2 : IdxWT3;
endfunction

function automatic int tagWOf(input int t);
    return (t == 1) ? TagWT1 : (t == 2) ? TagWT2 : TagWT3;
endfunction

// xor of width-sized slices of the low len bits, last slice zero padded
function automatic bit [31:0] foldChunks(input bit [63:0] value, input int len, input int width);
    bit [31:0] result;
    bit [63:0] chunk;
    int rem;
    int pos;
    result = '0;
    for (pos = 0; pos < len; pos += width) begin
        rem = (len - pos < width) ? len - pos : width;
        chunk = (value >> pos) & ((64'd1 << rem) - 64'd1);
        result = result ^ chunk[31:0];
    end
    return result;
endfunction

// base table takes PC bits alone, tagged tables mix in the history
function automatic bit [7:0] refIndex(input int t, input bit [31:0] pc);
    bit [31:0] full;
    full = (pc >> 2) & ((32'd1 << idxWOf(t)) - 32'd1);
    if (t > 0) begin
        full = full ^ foldChunks(refGhr, histOf(t), idxWOf(t));
    end
    return full[7:0];
endfunction

function automatic bit [31:0] refTagOf(input int t, input bit [31:0] pc);
    return foldChunks({32'd0, pc} >> (BaseIdxW + 2), PcWidth - BaseIdxW - 2, tagWOf(t))
        ^ foldChunks(refGhr, histOf(t), tagWOf(t));
endfunction

function automatic void refReset();
    int t;
    int i;
    for (t = 0; t < 4; t++) begin
        for (i = 0; i < 256; i++) begin
            refCtr[2'(t)][8'(i)] = int'(CtrReset);
            refValid[2'(t)][8'(i)] = 1'b0;
            refTag[2'(t)][8'(i)] = '0;
        end
    end
    refGhr = '0;
endfunction

// later tables overwrite earlier hits, so the longest match wins
function automatic void refPredict(input bit [31:0] pc, output int prov, output int ctr);
    int t;
    bit [7:0] idx;
    prov = 0;
    ctr = refCtr[0][refIndex(0, pc)];
    for (t = 1; t <= 3; t++) begin
        idx = refIndex(t, pc);
        if (refValid[2'(t)][idx] && refTag[2'(t)][idx] == refTagOf(t, pc)) begin
            prov = t;
            ctr = refCtr[2'(t)][idx];
        end
    end
endfunction

function automatic void refUpdate(input bit [31:0] pc, input bit taken, input int prov,
                                  input int ctr);
    int next;
    bit [7:0] idx;
    next = ctr;
    if (taken && ctr < 7) begin
        next = ctr + 1;
    end else if (!taken && ctr > 0) begin
        next = ctr - 1;
    end
    refCtr[2'(prov)][refIndex(prov, pc)] = next;
    // wrong direction grows the history by one table
    if (((ctr >= 4) != taken) && prov < 3) begin
        idx = refIndex(prov + 1, pc);
        refValid[2'(prov + 1)][idx] = 1'b1;
        refTag[2'(prov + 1)][idx] = refTagOf(prov + 1, pc);
        refCtr[2'(prov + 1)][idx] = taken ? int'(CtrWeakTaken) : int'(CtrWeakNotTaken);
    end
    refGhr = {refGhr[62:0], taken};
endfunction

`endif

//--- verif/tageTb.sv
`timescale 1ns/1ps

module tageTb;
    import tageGeomPkg::*;
    import tageEntryPkg::*;

    logic Clk;
    logic rst;
    logic TageStop;
    logic PcAble;
    pcT PcAddr;
    logic UpdateAble;
    pcT UpPc;
    logic UpTaken;
    providerT UpProvider;
    ctrT UpCounter;
    logic PredictAble;
    logic PredictTaken;
    providerT PredictProvider;
    ctrT PredictCounter;

    // stimulus table, -1 in a stall column means a random stall
    // -1 in an expected column leaves that row to the model alone
    bit [31:0] pcCol[$];
    bit takenCol[$];
    int stallCol[$];
    int expProvCol[$];
    int expCtrCol[$];
    string nameCol[$];
    int cycleCount = 0;

    `include "tageRefModel.svh"

    tageTop uut (
        .Clk(Clk), .rst(rst), .TageStop(TageStop), .PcAble(PcAble), .PcAddr(PcAddr),
        .UpdateAble(UpdateAble), .UpPc(UpPc), .UpTaken(UpTaken),
        .UpProvider(UpProvider), .UpCounter(UpCounter),
        .PredictAble(PredictAble), .PredictTaken(PredictTaken),
        .PredictProvider(PredictProvider), .PredictCounter(PredictCounter)
    );

    always #5 Clk = ~Clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= pcCol.size() * 20 + 50) begin
            abortRun($sformatf("Timeout, table not finished after %0d cycles", cycleCount));
        end
    end

    task automatic checkCtr(input string name, input ctrT expected, input ctrT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkProvider(input string name, input providerT expected,
                                 input providerT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected %0b, actual %0b", name, expected, actual));
        end
    endtask

    // drive and sample just after the rising edge
    task automatic nextCycle();
        @(posedge Clk);
        #1;
    endtask

    function automatic void addRow(input bit [31:0] pc, input bit taken, input int stall,
                                   input int expProv, input int expCtr, input string name);
        pcCol.push_back(pc);
        takenCol.push_back(taken);
        stallCol.push_back(stall);
        expProvCol.push_back(expProv);
        expCtrCol.push_back(expCtr);
        nameCol.push_back(name);
    endfunction

    task automatic runRow(input int r);
        int stallLen;
        int expProv;
        int expCtr;
        int i;
        providerT retProv;
        ctrT retCtr;
        logic retTaken;
        refPredict(pcCol[r], expProv, expCtr);
        stallLen = (stallCol[r] < 0) ? int'($urandom % 32'd4) + 1 : stallCol[r];
        PcAble = 1'b1;
        PcAddr = pcCol[r];
        nextCycle();
        PcAble = 1'b0;
        TageStop = (stallLen > 0);
        for (i = 0; i < stallLen; i++) begin
            nextCycle();
            checkBit({nameCol[r], " stalled PredictAble"}, 1'b0, PredictAble);
        end
        TageStop = 1'b0;
        nextCycle();
        checkBit({nameCol[r], " PredictAble"}, 1'b1, PredictAble);
        checkProvider({nameCol[r], " provider"}, providerT'(expProv), PredictProvider);
        checkCtr({nameCol[r], " counter"}, ctrT'(expCtr), PredictCounter);
        checkBit({nameCol[r], " taken"}, expCtr >= 4, PredictTaken);
        if (expProvCol[r] >= 0) begin
            checkProvider({nameCol[r], " table provider"}, providerT'(expProvCol[r]),
                          PredictProvider);
        end
        if (expCtrCol[r] >= 0) begin
            checkCtr({nameCol[r], " table counter"}, ctrT'(expCtrCol[r]), PredictCounter);
        end
        retProv = PredictProvider;
        retCtr = PredictCounter;
        retTaken = PredictTaken;
        // outputs must freeze while the prediction is held
        if (stallLen > 0) begin
            TageStop = 1'b1;
            nextCycle();
            TageStop = 1'b0;
            checkBit({nameCol[r], " held PredictAble"}, 1'b1, PredictAble);
            checkProvider({nameCol[r], " held provider"}, retProv, PredictProvider);
            checkCtr({nameCol[r], " held counter"}, retCtr, PredictCounter);
            checkBit({nameCol[r], " held taken"}, retTaken, PredictTaken);
        end
        UpdateAble = 1'b1;
        UpPc = pcCol[r];
        UpTaken = takenCol[r];
        UpProvider = retProv;
        UpCounter = retCtr;
        nextCycle();
        UpdateAble = 1'b0;
        refUpdate(pcCol[r], takenCol[r], int'(retProv), int'(retCtr));
    endtask

    function automatic void buildTable();
        int i;
        addRow(32'h0000_1000, 1'b1, 0, 0, 3, "first lookup A");
        addRow(32'h0000_1004, 1'b0, 2, 0, 3, "first lookup B");
        addRow(32'h0000_1008, 1'b0, 0, 0, 3, "first lookup C");
        addRow(32'h0000_100C, 1'b0, 1, 0, 3, "first lookup D");
        addRow(32'h0000_1010, 1'b0, 0, 0, 3, "first lookup E");
        // four not-taken outcomes bring back the history A was allocated with
        addRow(32'h0000_1000, 1'b1, 3, 1, 4, "T1 allocated weak taken");
        addRow(32'h0000_2040, 1'b1, 0, 0, 3, "saturate up 1");
        for (i = 2; i <= 4; i++) begin
            addRow(32'h0000_2040, 1'b1, -1, -1, -1, $sformatf("saturate up %0d", i));
        end
        addRow(32'h0000_2040, 1'b1, 2, 0, 7, "saturate up 5");
        addRow(32'h0000_2040, 1'b1, 0, 0, 7, "saturate up 6");
        addRow(32'h0000_2040, 1'b0, 0, 0, 7, "saturate down 1");
        for (i = 2; i <= 7; i++) begin
            addRow(32'h0000_2040, 1'b0, -1, -1, -1, $sformatf("saturate down %0d", i));
        end
        addRow(32'h0000_2040, 1'b0, 0, 0, 0, "saturate down 8");
        addRow(32'h0000_2040, 1'b0, 0, 0, 0, "saturate down 9");
        addRow(32'h0000_1000, 1'b0, 1, 1, 5, "T1 hit on repeated history");
        // mixed pattern, checked against the model only
        addRow(32'h0000_3000, 1'b1, -1, -1, -1, "mix 1");
        addRow(32'h0000_1000, 1'b1, -1, -1, -1, "mix 2");
        addRow(32'h0000_2040, 1'b0, -1, -1, -1, "mix 3");
        addRow(32'h0000_3000, 1'b1, -1, -1, -1, "mix 4");
        addRow(32'h0001_1004, 1'b0, -1, -1, -1, "mix 5");
        addRow(32'h0000_1000, 1'b1, -1, -1, -1, "mix 6");
        addRow(32'h0000_3000, 1'b0, -1, -1, -1, "mix 7");
        addRow(32'h0000_2040, 1'b1, -1, -1, -1, "mix 8");
        addRow(32'h0002_0008, 1'b1, -1, -1, -1, "mix 9");
        addRow(32'h0000_1000, 1'b0, -1, -1, -1, "mix 10");
    endfunction

    initial begin
        int r;
        Clk = 1'b0;
        rst = 1'b1;
        TageStop = 1'b0;
        PcAble = 1'b0;
        PcAddr = '0;
        UpdateAble = 1'b0;
        UpPc = '0;
        UpTaken = 1'b0;
        UpProvider = '0;
        UpCounter = '0;
        void'($urandom(36969));
        buildTable();
        refReset();
        repeat (8) @(posedge Clk);
        #1;
        rst = 1'b0;
        // no lookup issued yet
        for (r = 0; r < 3; r++) begin
            nextCycle();
            checkBit("idle after reset PredictAble", 1'b0, PredictAble);
        end
        for (r = 0; r < pcCol.size(); r++) begin
            runRow(r);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+verif
common/tageGeomPkg.sv
common/tageEntryPkg.sv
verilog/indexHash.sv
predict/predTable.sv
predict/providerSelect.sv
update/updateUnit.sv
verilog/tageTop.sv
verif/tageTb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tageTb -o tageSim > sim.log 2>&1 \
    && ./obj_dir/tageSim >> sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no result, see sim.log"; exit 1; }
echo "PASS"
